/* srt_config.svh */
// SRT divider and square-root configuration
// Operand, mantissa and residual widths shared by every block

`ifndef SRT_CONFIG_SVH
`define SRT_CONFIG_SVH

// Integer operand width
`define XLEN 32

// Normalized mantissa width
// Operand width plus guard bits, rounded up to an even count
`define DIVLEN (((`XLEN + 3) / 2) * 2)

// Carry-save residual width, four integer bits above the mantissa
`define RESLEN (`DIVLEN + 4)

// Width of iteration and shift counts
`define CNTW $clog2(`XLEN + 1)

`endif

/* divIfPkg.sv */
// SRT unit port types
// Request and response structures seen at the top level

`include "srt_config.svh"

package divIfPkg;

  // Operation select
  typedef enum logic {
    opDiv  = 1'b0,
    opSqrt = 1'b1
  } srtOpE;

  // One request, issued with start
  // b is ignored for square root
  typedef struct packed {
    srtOpE             op;
    logic [`XLEN-1:0]  a;
    logic [`XLEN-1:0]  b;
  } srtReqT;

  // Result, held from done until the next accepted start
  typedef struct packed {
    logic [`XLEN-1:0]  res;
    logic [`XLEN-1:0]  rem;
    logic              divByZero;
  } srtRspT;

endpackage

/* srtDatapathPkg.sv */
// SRT datapath types
// Residual, digit, preparation and converter state structures

`include "srt_config.svh"

package srtDatapathPkg;
  import divIfPkg::*;

  // One-hot result digit +1, 0, -1
  typedef struct packed {
    logic qp;
    logic qz;
    logic qn;
  } srtDigitT;

  // Residual in carry-save form
  typedef struct packed {
    logic [`RESLEN-1:0] ws;
    logic [`RESLEN-1:0] wc;
  } srtResidualT;

  // Preprocessed operation
  typedef struct packed {
    srtOpE              op;
    logic [`RESLEN-1:0] x;
    logic [`RESLEN-1:0] d;
    logic [`CNTW-1:0]   dur;
    logic [`CNTW-1:0]   shift;
    logic               divByZero;
  } srtPrepT;

  // On-the-fly converter state, S and S minus one ulp
  typedef struct packed {
    logic [`RESLEN-1:0] s;
    logic [`RESLEN-1:0] sm;
  } srtRootT;

endpackage

/* srtPreproc.sv */
// SRT operand preprocessing
// Normalizes the operands by leading-zero count, builds the start
// residual and the divisor, and derives iteration count and shift

`timescale 1ns/1ps

`include "srt_config.svh"

module srtPreproc
  import divIfPkg::*;
  import srtDatapathPkg::*;
(
  input  srtReqT  req,
  output srtPrepT prep
);

  localparam int Xlen   = `XLEN;
  localparam int Divlen = `DIVLEN;
  localparam int Reslen = `RESLEN;
  localparam int Cntw   = `CNTW;
  // Fraction bits below the operand once it sits under the integer one
  localparam int Guard  = Divlen - Xlen + 1;

  logic [Cntw-1:0]   lzA, lzB, normShift, sqShift;
  logic [Xlen-1:0]   aDiv, aSq, bNorm;
  logic [Reslen-1:0] xDiv, xSq, sqrtTwo;
  logic              isSqrt, zeroDiv;

  // Leading zeros, XLEN for a zero word
  function automatic logic [Cntw-1:0] lzc(input logic [Xlen-1:0] v);
    logic [Cntw-1:0] n;
    logic            found;
    n = Cntw'(Xlen);
    found = 1'b0;
    for (int i = Xlen - 1; i >= 0; i--) begin
      if (!found && v[i]) begin
        n = Cntw'(Xlen - 1 - i);
        found = 1'b1;
      end
    end
    return n;
  endfunction

  assign isSqrt = (req.op == opSqrt);
  assign lzA = lzc(req.a);
  assign lzB = lzc(req.b);
  assign zeroDiv = !isSqrt && (req.b == '0);

  ////////////////////
  // Division
  ////////////////////
  // Dividend shift never exceeds the divisor shift, keeps dur >= 1
  assign normShift = (lzA < lzB) ? lzA : lzB;
  assign aDiv = req.a << normShift;
  assign bNorm = req.b << lzB;
  assign xDiv = {3'b000, aDiv, {Guard{1'b0}}};

  ////////////////////
  // Square root
  ////////////////////
  // Even shift, odd lzc leaves the radicand in [1/4,1/2)
  assign sqShift = {lzA[Cntw-1:1], 1'b0};
  assign aSq = req.a << sqShift;
  // Start residual is 2*(x - 1) with S starting at 1
  assign sqrtTwo = Reslen'(2) << Divlen;
  assign xSq = {3'b000, aSq, {Guard{1'b0}}} - sqrtTwo;

  assign prep.op = req.op;
  assign prep.x = isSqrt ? xSq : xDiv;
  assign prep.d = {3'b000, bNorm, {Guard{1'b0}}};
  assign prep.divByZero = zeroDiv;

  // Quotient digits from the exponent difference, fixed for root
  always_comb begin
    if (isSqrt) begin
      prep.dur = Cntw'(Divlen / 2 + 1);
      prep.shift = sqShift;
    end else if (zeroDiv) begin
      prep.dur = Cntw'(1);
      prep.shift = normShift;
    end else begin
      prep.dur = lzB - normShift + Cntw'(1);
      prep.shift = lzB;
    end
  end

endmodule

/* srtResidualStep.sv */
// SRT residual iteration
// Holds the carry-save residual and the registered preparation,
// selects the next digit and forms the next residual through a CSA

`timescale 1ns/1ps

`include "srt_config.svh"

module srtResidualStep
  import divIfPkg::*;
  import srtDatapathPkg::*;
(
  input  logic              clk,
  input  logic              arstN,
  input  logic              load,
  input  logic              iterate,
  input  srtPrepT           prepIn,
  input  logic [`RESLEN-1:0] f,
  output srtDigitT          digit,
  output srtResidualT       resid,
  output srtPrepT           prepReg
);

  localparam int Reslen = `RESLEN;

  logic [Reslen-1:0] addIn, dSel, wsA, wcA;
  logic [3:0]        est;
  logic              cin, isSqrt;

  assign isSqrt = (prepReg.op == opSqrt);

  ////////////////////
  // Registers
  ////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      prepReg <= '0;
      resid <= '0;
    end else if (load) begin
      // New operation, whole preparation held for postprocessing
      prepReg <= prepIn;
      resid.ws <= prepIn.x;
      resid.wc <= '0;
    end else if (iterate) begin
      // Stored value is already twice the residual
      resid.ws <= {wsA[Reslen-2:0], 1'b0};
      resid.wc <= {wcA[Reslen-2:0], 1'b0};
    end
  end

  ////////////////////
  // Digit selection
  ////////////////////
  // Estimate from the four integer bits of each carry-save word
  assign est = resid.ws[Reslen-1:Reslen-4] + resid.wc[Reslen-1:Reslen-4];

  // -1 gives zero digit, any other negative gives -1
  assign digit.qz = (est == 4'b1111);
  assign digit.qp = !est[3];
  assign digit.qn = est[3] && !digit.qz;

  // Divisor term, ~d with carry-in subtracts d
  always_comb begin
    if (digit.qp) begin
      dSel = ~prepReg.d;
    end else if (digit.qz) begin
      dSel = '0;
    end else begin
      dSel = prepReg.d;
    end
  end

  // Root term already comes in two's complement form
  assign addIn = isSqrt ? f : dSel;
  assign cin = !isSqrt && digit.qp;

  ////////////////////
  // Carry-save adder
  ////////////////////
  assign wsA = resid.ws ^ resid.wc ^ addIn;
  assign wcA = {(resid.ws[Reslen-2:0] & resid.wc[Reslen-2:0]) |
                (resid.ws[Reslen-2:0] & addIn[Reslen-2:0]) |
                (resid.wc[Reslen-2:0] & addIn[Reslen-2:0]), cin};

endmodule

/* srtOnTheFlyConv.sv */
// SRT on-the-fly converter
// Builds the quotient or root and its decremented copy as digits
// arrive, and forms the square-root adder input

`timescale 1ns/1ps

`include "srt_config.svh"

module srtOnTheFlyConv
  import divIfPkg::*;
  import srtDatapathPkg::*;
(
  input  logic               clk,
  input  logic               arstN,
  input  logic               load,
  input  logic               iterate,
  input  srtOpE              op,
  input  srtDigitT           digit,
  output srtRootT            root,
  output logic [`RESLEN-1:0] f
);

  localparam int Reslen = `RESLEN;
  localparam int Divlen = `DIVLEN;

  logic [Reslen-1:0] c, bitPos, fPos, fNeg;
  logic              isSqrt;

  assign isSqrt = (op == opSqrt);

  // Weight of the digit being resolved, lowest one of C
  assign bitPos = c & ~(c << 1);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      c <= '0;
      root <= '0;
    end else if (load) begin
      // First digit weight is 1 for division, 1/2 for root
      c <= {4'b1111, isSqrt, {(Divlen - 1){1'b0}}};
      root.s <= {3'b000, isSqrt, {Divlen{1'b0}}};
      root.sm <= '0;
    end else if (iterate) begin
      c <= {1'b1, c[Reslen-1:1]};
      if (digit.qp) begin
        root.s <= root.s | bitPos;
        root.sm <= root.s;
      end else if (digit.qn) begin
        root.s <= root.sm | bitPos;
        root.sm <= root.sm;
      end else begin
        root.s <= root.s;
        root.sm <= root.sm | bitPos;
      end
    end
  end

  ////////////////////
  // Root adder input
  ////////////////////
  // +1 digit subtracts 2S plus the new weight
  assign fPos = ~(root.s << 1) & c;
  // -1 digit adds 2SM plus three times the new weight
  assign fNeg = (root.sm << 1) | (c & (~c << 2));

  always_comb begin
    if (digit.qp) begin
      f = fPos;
    end else if (digit.qn) begin
      f = fNeg;
    end else begin
      f = '0;
    end
  end

endmodule

/* srtSequencer.sv */
// SRT sequencer
// Accepts a start while idle, counts the iterations and pulses done

`timescale 1ns/1ps

`include "srt_config.svh"

module srtSequencer (
  input  logic            clk,
  input  logic            arstN,
  input  logic            start,
  input  logic            flush,
  input  logic [`CNTW-1:0] dur,
  output logic            load,
  output logic            busy,
  output logic            done
);

  logic [`CNTW-1:0] cnt, durQ;

  // Start while busy is dropped
  assign load = start && !busy;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt <= '0;
      durQ <= '0;
    end else begin
      done <= 1'b0;
      if (load) begin
        busy <= 1'b1;
        cnt <= '0;
        durQ <= dur;
      end else if (busy) begin
        if (flush) begin
          // Abort without a done pulse
          busy <= 1'b0;
        end else if (cnt == durQ - 1'b1) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

endmodule

/* srtPostproc.sv */
// SRT postprocessing
// Resolves the residual sign, picks S or SM, restores the remainder
// and shifts results back to integer scale

`timescale 1ns/1ps

`include "srt_config.svh"

module srtPostproc
  import divIfPkg::*;
  import srtDatapathPkg::*;
(
  input  srtResidualT resid,
  input  srtRootT     root,
  input  srtPrepT     prep,
  output srtRspT      rsp
);

  localparam int Xlen   = `XLEN;
  localparam int Divlen = `DIVLEN;
  localparam int Reslen = `RESLEN;
  localparam int Guard  = Divlen - Xlen + 1;

  logic [Reslen-1:0] wSum, w, rootSel, remW, quotFull, remFull, rootFull;
  logic [Reslen-1:0] aNorm, sqrtTwo;
  logic [Xlen-1:0]   aOrig, quot, divRem, sqRoot, sqRem;
  logic              neg, isSqrt;

  assign isSqrt = (prep.op == opSqrt);

  ////////////////////
  // Residual sign
  ////////////////////
  // Register holds twice the final residual
  assign wSum = resid.ws + resid.wc;
  assign w = {wSum[Reslen-1], wSum[Reslen-1:1]};
  assign neg = w[Reslen-1];

  // Negative residual means the last digit overshot by one ulp
  assign rootSel = neg ? root.sm : root.s;
  assign remW = neg ? w + prep.d : w;

  // Original a recovered from the start residual
  assign sqrtTwo = Reslen'(2) << Divlen;
  assign aNorm = (isSqrt ? prep.x + sqrtTwo : prep.x) >> Guard;
  assign aOrig = aNorm[Xlen-1:0] >> prep.shift;

  ////////////////////
  // Division
  ////////////////////
  // Last digit sits dur-1 places below the integer one
  assign quotFull = rootSel >> (Divlen + 1 - prep.dur);
  assign quot = quotFull[Xlen-1:0];
  assign remFull = remW >> (Guard + prep.shift);
  assign divRem = remFull[Xlen-1:0];

  ////////////////////
  // Square root
  ////////////////////
  // Half the radicand shift comes back out of the root
  assign rootFull = rootSel >> (Divlen - Xlen / 2 + prep.shift / 2);
  assign sqRoot = rootFull[Xlen-1:0];
  assign sqRem = aOrig - sqRoot * sqRoot;

  always_comb begin
    rsp.divByZero = prep.divByZero;
    if (isSqrt) begin
      rsp.res = sqRoot;
      rsp.rem = sqRem;
    end else if (prep.divByZero) begin
      rsp.res = '1;
      rsp.rem = aOrig;
    end else begin
      rsp.res = quot;
      rsp.rem = divRem;
    end
  end

endmodule

/* srtDivSqrt.sv */
// Radix-2 SRT integer divide and square root
// One operation at a time, start strobe in and done pulse out

`timescale 1ns/1ps

`include "srt_config.svh"

module srtDivSqrt
  import divIfPkg::*;
  import srtDatapathPkg::*;
(
  input  logic   clk,
  input  logic   arstN,
  input  logic   start,
  input  logic   flush,
  input  srtReqT req,
  output logic   busy,
  output logic   done,
  output srtRspT rsp
);

  srtPrepT              prep, prepReg;
  srtDigitT             digit;
  srtResidualT          resid;
  srtRootT              root;
  logic [`RESLEN-1:0]   f;
  logic                 load;

  srtPreproc srtPreproc_i (
    .req  (req),
    .prep (prep)
  );

  srtSequencer srtSequencer_i (
    .clk   (clk),
    .arstN (arstN),
    .start (start),
    .flush (flush),
    .dur   (prep.dur),
    .load  (load),
    .busy  (busy),
    .done  (done)
  );

  // Datapath advances on every busy cycle
  srtResidualStep srtResidualStep_i (
    .clk     (clk),
    .arstN   (arstN),
    .load    (load),
    .iterate (busy),
    .prepIn  (prep),
    .f       (f),
    .digit   (digit),
    .resid   (resid),
    .prepReg (prepReg)
  );

  srtOnTheFlyConv srtOnTheFlyConv_i (
    .clk     (clk),
    .arstN   (arstN),
    .load    (load),
    .iterate (busy),
    .op      (req.op),
    .digit   (digit),
    .root    (root),
    .f       (f)
  );

  srtPostproc srtPostproc_i (
    .resid (resid),
    .root  (root),
    .prep  (prepReg),
    .rsp   (rsp)
  );

endmodule

/* srtDivSqrtTb.sv */
// Testbench for the radix-2 SRT divide and square-root unit
// Drives division, divide by zero, square root, ignored starts and
// flush, and checks every result with concurrent assertions

`timescale 1ns/1ps

`include "srt_config.svh"

module srtDivSqrtTb
  import divIfPkg::*;
();

  localparam int ResetCycles   = 10;
  localparam int NumOps        = 64;
  localparam int TimeoutCycles = NumOps * (`XLEN + 4) + 20 * ResetCycles;

  logic clk, arstN, start, flush, busy, done;
  srtReqT req;
  srtRspT rsp, heldRsp;

  // Reference values, set only when a start is accepted
  logic [`XLEN-1:0] expRes, expRem, rndA, rndB;
  logic             expDbz, started, pending, holdValid;
  logic [31:0]      rngState;
  int               cycleCnt;

  srtDivSqrt srtDivSqrt_i (
    .clk   (clk),
    .arstN (arstN),
    .start (start),
    .flush (flush),
    .req   (req),
    .busy  (busy),
    .done  (done),
    .rsp   (rsp)
  );

  always #4 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Floor square root, one result bit per step from the top
  function automatic logic [`XLEN-1:0] isqrt(input logic [`XLEN-1:0] v);
    logic [`XLEN-1:0] r, t;
    r = '0;
    for (int i = `XLEN / 2 - 1; i >= 0; i--) begin
      t = r | (`XLEN'(1) << i);
      if (64'(t) * 64'(t) <= 64'(v)) begin
        r = t;
      end
    end
    return r;
  endfunction

  task automatic reportMismatch(input string name, input logic [2*`XLEN:0] expV,
                                input logic [2*`XLEN:0] actV);
    $display("FAILED time=%0t signal=%s expected=%h actual=%h", $time, name, expV, actV);
    $display("Simulation failed");
    $fatal(1, "value check failed");
  endtask

  task automatic reportError(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "protocol check failed");
  endtask

  // Waits for idle, then strobes start and records the reference result
  task automatic issueOp(input srtOpE op, input logic [`XLEN-1:0] a,
                         input logic [`XLEN-1:0] b);
    while (busy) @(negedge clk);
    req.op = op;
    req.a = a;
    req.b = b;
    if (op == opSqrt) begin
      expRes = isqrt(a);
      expRem = a - expRes * expRes;
      expDbz = 1'b0;
    end else if (b == '0) begin
      expRes = '1;
      expRem = a;
      expDbz = 1'b1;
    end else begin
      expRes = a / b;
      expRem = a % b;
      expDbz = 1'b0;
    end
    start = 1'b1;
    started = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  // One extra edge lets the done checks see the reference values
  task automatic waitDone();
    while (!done) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic runOp(input srtOpE op, input logic [`XLEN-1:0] a,
                       input logic [`XLEN-1:0] b);
    logic [1:0] gap;
    issueOp(op, a, b);
    waitDone();
    rngState = xorshift32(rngState);
    gap = rngState[1:0];
    repeat (gap) @(negedge clk);
  endtask

  ////////////////////
  // Tracking
  ////////////////////
  // Outstanding operation and the result that has to hold after done
  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pending <= 1'b0;
      holdValid <= 1'b0;
      heldRsp <= '0;
    end else begin
      if (done) begin
        pending <= 1'b0;
        holdValid <= 1'b1;
        heldRsp <= rsp;
      end
      if (busy && flush) begin
        pending <= 1'b0;
      end
      // Accept wins over a done in the same cycle
      if (start && !busy) begin
        pending <= 1'b1;
        holdValid <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= TimeoutCycles) begin
      $display("ERROR: run timed out after %0d cycles", cycleCnt);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  ////////////////////
  // Assertions
  ////////////////////
  resetIdle: assert property (@(posedge clk) disable iff (!arstN)
      !started |-> (!busy && !done && rsp == '0))
    else reportError("unit not idle with zero result after reset");

  resCheck: assert property (@(posedge clk) disable iff (!arstN)
      done |-> rsp.res == expRes)
    else reportMismatch("rsp.res", $sampled(expRes), $sampled(rsp.res));

  remCheck: assert property (@(posedge clk) disable iff (!arstN)
      done |-> rsp.rem == expRem)
    else reportMismatch("rsp.rem", $sampled(expRem), $sampled(rsp.rem));

  dbzCheck: assert property (@(posedge clk) disable iff (!arstN)
      done |-> rsp.divByZero == expDbz)
    else reportMismatch("rsp.divByZero", $sampled(expDbz), $sampled(rsp.divByZero));

  doneOnce: assert property (@(posedge clk) disable iff (!arstN)
      done |-> pending)
    else reportError("done pulse without an outstanding operation");

  doneIdle: assert property (@(posedge clk) disable iff (!arstN)
      done |-> !busy)
    else reportError("done pulse while busy is still high");

  acceptBusy: assert property (@(posedge clk) disable iff (!arstN)
      start && !busy |=> busy)
    else reportError("busy did not rise after an accepted start");

  // Busy only ends with done unless flushed
  runEnd: assert property (@(posedge clk) disable iff (!arstN)
      busy && !flush |=> busy || done)
    else reportError("busy fell without a done pulse");

  flushDrop: assert property (@(posedge clk) disable iff (!arstN)
      busy && flush |=> !busy && !done)
    else reportError("flush did not end the operation cleanly");

  holdRsp: assert property (@(posedge clk) disable iff (!arstN)
      holdValid |-> rsp == heldRsp)
    else reportMismatch("rsp", $sampled(heldRsp), $sampled(rsp));

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin
    clk = 1'b0;
    arstN = 1'b0;
    start = 1'b0;
    flush = 1'b0;
    req = '0;
    expRes = '0;
    expRem = '0;
    expDbz = 1'b0;
    started = 1'b0;
    cycleCnt = 0;
    rngState = 32'h9fbada6f;
    repeat (ResetCycles) @(negedge clk);
    arstN = 1'b1;
    // Idle stretch for the reset check
    repeat (5) @(negedge clk);

    // Division edge pairs
    runOp(opDiv, 32'd5, 32'd7);
    runOp(opDiv, 32'd12345, 32'd12345);
    runOp(opDiv, 32'hDEADBEEF, 32'd1);
    runOp(opDiv, 32'hFFFFFFFF, 32'd3);
    runOp(opDiv, 32'hFFFFFFFF, 32'hFFFFFFFF);
    runOp(opDiv, 32'd0, 32'd5);
    runOp(opDiv, 32'd100, 32'd10);
    runOp(opDiv, 32'd1, 32'hFFFFFFFF);

    // Zero divisor
    runOp(opDiv, 32'h00001234, 32'd0);
    runOp(opDiv, 32'd0, 32'd0);

    // Square root corners and perfect squares
    runOp(opSqrt, 32'd0, 32'd0);
    runOp(opSqrt, 32'd1, 32'd0);
    runOp(opSqrt, 32'd2, 32'd0);
    runOp(opSqrt, 32'd3, 32'd0);
    runOp(opSqrt, 32'd4, 32'd0);
    runOp(opSqrt, 32'd144, 32'd0);
    runOp(opSqrt, 32'd65536, 32'd0);
    runOp(opSqrt, 32'hFFFE0001, 32'd0);
    runOp(opSqrt, 32'hFFFFFFFF, 32'd0);

    // Random division, divisor width varied by a random shift
    for (int i = 0; i < 16; i++) begin
      rngState = xorshift32(rngState);
      rndA = rngState;
      rngState = xorshift32(rngState);
      rndB = rngState >> rngState[4:0];
      if (rndB == '0) begin
        rndB = 32'd1;
      end
      runOp(opDiv, rndA, rndB);
    end

    // Random square root
    for (int i = 0; i < 16; i++) begin
      rngState = xorshift32(rngState);
      rndA = rngState;
      rngState = xorshift32(rngState);
      rndA = rndA >> rngState[4:0];
      runOp(opSqrt, rndA, 32'd0);
    end

    // Start while busy must be ignored
    issueOp(opDiv, 32'hFFFFFFF0, 32'd7);
    repeat (3) @(negedge clk);
    req.op = opSqrt;
    req.a = 32'h0BADF00D;
    req.b = 32'd3;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    waitDone();

    // Flush in the middle of a long division
    issueOp(opDiv, 32'hFFFFFFFF, 32'd1);
    repeat (5) @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    repeat (3) @(negedge clk);
    runOp(opDiv, 32'd1000003, 32'd97);

    repeat (4) @(negedge clk);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* build.f */
+incdir+.
divIfPkg.sv
srtDatapathPkg.sv
srtPreproc.sv
srtResidualStep.sv
srtOnTheFlyConv.sv
srtSequencer.sv
srtPostproc.sv
srtDivSqrt.sv
srtDivSqrtTb.sv
